//--- source/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

	// --------------------
	// field widths
	// --------------------
	localparam int inst_len = 44;
	localparam int fn_len = 3;
	localparam int name_len = 3;
	localparam int index_len = 8;
	localparam int weight_addr_len = 5;
	localparam int data_addr_len = 5;
	localparam int interim_addr_len = 2;
	localparam int meta_addr_len = 2;
	localparam int bus_index_len = 4;
	// bit 0 of a bus index is the strobe slot
	localparam int bus_addr_len = bus_index_len - 1;

	// --------------------
	// field positions, lowest bit of each
	// --------------------
	// built up from bit 0, destinations sit at the bottom of the word
	localparam int dest_gb_bus_index_lsb = 0;
	localparam int dest_pe_bus_index_lsb = dest_gb_bus_index_lsb + bus_index_len;
	localparam int dest_pu_neigh_bit = dest_pe_bus_index_lsb + bus_index_len;
	localparam int dest_pe_neigh_bit = dest_pu_neigh_bit + 1;
	localparam int dest_weight_addr_lsb = dest_pe_neigh_bit + 1;
	localparam int dest_weight_wrt_bit = dest_weight_addr_lsb + weight_addr_len;
	localparam int dest_interim_addr_lsb = dest_weight_wrt_bit + 1;
	localparam int dest_interim_wrt_bit = dest_interim_addr_lsb + interim_addr_len;
	localparam int src1_index_lsb = dest_interim_wrt_bit + 1;
	localparam int src1_name_lsb = src1_index_lsb + index_len;
	localparam int src0_index_lsb = src1_name_lsb + name_len;
	localparam int src0_name_lsb = src0_index_lsb + index_len;
	localparam int fn_lsb = src0_name_lsb + name_len;

	// --------------------
	// source namespaces
	// --------------------
	localparam logic [name_len-1:0] ns_none = 3'd0;
	localparam logic [name_len-1:0] ns_weight = 3'd1;
	localparam logic [name_len-1:0] ns_data = 3'd2;
	localparam logic [name_len-1:0] ns_interim = 3'd3;
	localparam logic [name_len-1:0] ns_meta = 3'd4;
	localparam logic [name_len-1:0] ns_neighbor = 3'd5;
	localparam logic [name_len-1:0] ns_bus = 3'd6;

	// routed view of an index
	// side 0 is the PE neighbor or PE bus, side 1 the PU neighbor or global bus
	typedef struct packed {
		logic [index_len-2:0] addr;
		logic side;
	} src_route_t;

	// memory sources read raw low bits, neighbor and bus sources read the routed form
	typedef union packed {
		logic [index_len-1:0] raw;
		src_route_t route;
	} src_index_u;

endpackage

`default_nettype wire

//--- source/inst_field_split.sv
`timescale 1ns/1ps
`default_nettype none

module inst_field_split (
	input  wire [pe_ctrl_pkg::inst_len-1:0] inst_in,
	input  wire inst_in_v,
	output logic [pe_ctrl_pkg::fn_len-1:0] fn,
	output logic [pe_ctrl_pkg::name_len-1:0] src0_name,
	output logic [pe_ctrl_pkg::index_len-1:0] src0_index,
	output logic [pe_ctrl_pkg::name_len-1:0] src1_name,
	output logic [pe_ctrl_pkg::index_len-1:0] src1_index,
	output logic weight_wrt,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_wrt_addr,
	output logic interim_wrt,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_wrt_addr,
	output logic pe_neigh_wrt,
	output logic pu_neigh_wrt,
	output logic pe_bus_wrt,
	output logic gb_bus_wrt,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] pe_bus_wrt_addr,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] gb_bus_wrt_addr,
	output logic eol
);

	// raw destination flags, before valid gating
	logic dest_weight;
	logic dest_interim;
	logic dest_pe_neigh;
	logic dest_pu_neigh;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] pe_bus_dest;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] gb_bus_dest;

	// --------------------
	// source and function fields
	// --------------------
	assign fn = inst_in[pe_ctrl_pkg::fn_lsb +: pe_ctrl_pkg::fn_len];
	assign src0_name = inst_in[pe_ctrl_pkg::src0_name_lsb +: pe_ctrl_pkg::name_len];
	assign src0_index = inst_in[pe_ctrl_pkg::src0_index_lsb +: pe_ctrl_pkg::index_len];
	assign src1_name = inst_in[pe_ctrl_pkg::src1_name_lsb +: pe_ctrl_pkg::name_len];
	assign src1_index = inst_in[pe_ctrl_pkg::src1_index_lsb +: pe_ctrl_pkg::index_len];

	// --------------------
	// destinations
	// --------------------
	assign dest_weight = inst_in[pe_ctrl_pkg::dest_weight_wrt_bit];
	assign dest_interim = inst_in[pe_ctrl_pkg::dest_interim_wrt_bit];
	assign dest_pe_neigh = inst_in[pe_ctrl_pkg::dest_pe_neigh_bit];
	assign dest_pu_neigh = inst_in[pe_ctrl_pkg::dest_pu_neigh_bit];
	// upper three bits of each bus index, zero means no bus write
	assign pe_bus_dest = inst_in[pe_ctrl_pkg::dest_pe_bus_index_lsb + 1 +: pe_ctrl_pkg::bus_addr_len];
	assign gb_bus_dest = inst_in[pe_ctrl_pkg::dest_gb_bus_index_lsb + 1 +: pe_ctrl_pkg::bus_addr_len];

	assign weight_wrt = dest_weight && inst_in_v;
	assign interim_wrt = dest_interim && inst_in_v;
	assign pe_neigh_wrt = dest_pe_neigh && inst_in_v;
	assign pu_neigh_wrt = dest_pu_neigh && inst_in_v;
	assign pe_bus_wrt = (|pe_bus_dest) && inst_in_v;
	assign gb_bus_wrt = (|gb_bus_dest) && inst_in_v;

	assign weight_wrt_addr = weight_wrt ?
		inst_in[pe_ctrl_pkg::dest_weight_addr_lsb +: pe_ctrl_pkg::weight_addr_len] : '0;
	assign interim_wrt_addr = interim_wrt ?
		inst_in[pe_ctrl_pkg::dest_interim_addr_lsb +: pe_ctrl_pkg::interim_addr_len] : '0;
	assign pe_bus_wrt_addr = pe_bus_wrt ? pe_bus_dest : '0;
	assign gb_bus_wrt_addr = gb_bus_wrt ? gb_bus_dest : '0;

	// end of list: nothing read, nothing written
	assign eol = inst_in_v
		&& (src0_name == pe_ctrl_pkg::ns_none)
		&& (src1_name == pe_ctrl_pkg::ns_none)
		&& !(dest_weight || dest_interim || dest_pe_neigh || dest_pu_neigh)
		&& !((|pe_bus_dest) || (|gb_bus_dest));

endmodule

`default_nettype wire

//--- source/src_operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module src_operand_decode (
	input  wire [pe_ctrl_pkg::name_len-1:0] name,
	input  wire pe_ctrl_pkg::src_index_u index,
	input  wire valid,
	output logic [pe_ctrl_pkg::data_addr_len-1:0] data_rd_addr,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_rd_addr,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr,
	output logic [pe_ctrl_pkg::meta_addr_len-1:0] meta_rd_addr,
	output logic pe_neigh_rq,
	output logic pu_neigh_rq,
	output logic pe_bus_rq,
	output logic gb_bus_rq,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] bus_rd_addr,
	output logic rq
);

	logic is_weight;
	logic is_data;
	logic is_interim;
	logic is_meta;
	logic is_neigh;
	logic is_bus;

	// --------------------
	// name decode
	// --------------------
	assign is_weight = (name == pe_ctrl_pkg::ns_weight);
	assign is_data = (name == pe_ctrl_pkg::ns_data);
	assign is_interim = (name == pe_ctrl_pkg::ns_interim);
	assign is_meta = (name == pe_ctrl_pkg::ns_meta);
	assign is_neigh = (name == pe_ctrl_pkg::ns_neighbor);
	assign is_bus = (name == pe_ctrl_pkg::ns_bus);

	// --------------------
	// memory reads, raw view
	// --------------------
	// only the matching memory sees a non-zero address
	assign data_rd_addr = is_data ? index.raw[pe_ctrl_pkg::data_addr_len-1:0] : '0;
	assign weight_rd_addr = is_weight ? index.raw[pe_ctrl_pkg::weight_addr_len-1:0] : '0;
	assign interim_rd_addr = is_interim ?
		index.raw[pe_ctrl_pkg::interim_addr_len-1:0] : '0;
	assign meta_rd_addr = is_meta ? index.raw[pe_ctrl_pkg::meta_addr_len-1:0] : '0;

	// --------------------
	// neighbor and bus, routed view
	// --------------------
	assign pe_neigh_rq = valid && is_neigh && !index.route.side;
	assign pu_neigh_rq = valid && is_neigh && index.route.side;
	assign pe_bus_rq = valid && is_bus && !index.route.side;
	assign gb_bus_rq = valid && is_bus && index.route.side;

	// bus slot number sits just above the side bit
	assign bus_rd_addr = is_bus ? index.route.addr[pe_ctrl_pkg::bus_addr_len-1:0] : '0;

	assign rq = valid && (name != pe_ctrl_pkg::ns_none);

	// one source feeds at most one data path
	always_comb
	begin
		a_one_rq: assert ($onehot0({pe_neigh_rq, pu_neigh_rq, pe_bus_rq, gb_bus_rq}))
			else $error("src_operand_decode: more than one path request");
	end

endmodule

`default_nettype wire

//--- source/pe_ctrl_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl_pipe (
	input  wire clk,
	input  wire arst_n,
	input  wire eoc,
	input  wire advance,
	input  wire inst_v,
	input  wire [pe_ctrl_pkg::fn_len-1:0] fn_d,
	input  wire weight_wrt_d,
	input  wire [pe_ctrl_pkg::weight_addr_len-1:0] weight_wrt_addr_d,
	input  wire interim_wrt_d,
	input  wire [pe_ctrl_pkg::interim_addr_len-1:0] interim_wrt_addr_d,
	input  wire pe_neigh_wrt_d,
	input  wire pu_neigh_wrt_d,
	input  wire [pe_ctrl_pkg::bus_index_len-1:0] pe_bus_wrt_addr_d,
	input  wire [pe_ctrl_pkg::bus_index_len-1:0] gb_bus_wrt_addr_d,
	input  wire [pe_ctrl_pkg::data_addr_len-1:0] data_rd_addr_d,
	input  wire [pe_ctrl_pkg::weight_addr_len-1:0] weight_rd_addr_d,
	input  wire [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr0_d,
	input  wire [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr1_d,
	input  wire [pe_ctrl_pkg::meta_addr_len-1:0] meta_rd_addr_d,
	input  wire pe_neigh_data_rq_d,
	input  wire pu_neigh_data_rq_d,
	input  wire pe_bus_data_rq_d,
	input  wire gb_bus_data_rq_d,
	input  wire [pe_ctrl_pkg::bus_addr_len-1:0] bus_rd_addr_d,
	input  wire src0_rq_d,
	input  wire src1_rq_d,
	input  wire [pe_ctrl_pkg::index_len-1:0] src0_index_d,
	input  wire [pe_ctrl_pkg::index_len-1:0] src1_index_d,
	input  wire [pe_ctrl_pkg::name_len-1:0] src0_name_d,
	input  wire [pe_ctrl_pkg::name_len-1:0] src1_name_d,
	input  wire eol_d,
	output logic [pe_ctrl_pkg::fn_len-1:0] pe_compute_fn,
	output logic inst_out_v,
	output logic weight_wrt,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_wrt_addr,
	output logic interim_wrt,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_wrt_addr,
	output logic pe_neigh_wrt,
	output logic pu_neigh_wrt,
	output logic [pe_ctrl_pkg::bus_index_len-1:0] pe_bus_wrt_addr,
	output logic [pe_ctrl_pkg::bus_index_len-1:0] gb_bus_wrt_addr,
	output logic [pe_ctrl_pkg::data_addr_len-1:0] data_rd_addr,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_rd_addr,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr0,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr1,
	output logic [pe_ctrl_pkg::meta_addr_len-1:0] meta_rd_addr,
	output logic pe_neigh_data_rq,
	output logic pu_neigh_data_rq,
	output logic pe_bus_data_rq,
	output logic gb_bus_data_rq,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] pe_bus_rd_addr,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] gb_bus_rd_addr,
	output logic src0_rq,
	output logic src1_rq,
	output logic [pe_ctrl_pkg::index_len-1:0] src0_index,
	output logic [pe_ctrl_pkg::index_len-1:0] src1_index,
	output logic [pe_ctrl_pkg::name_len-1:0] src0_name,
	output logic [pe_ctrl_pkg::name_len-1:0] src1_name,
	output logic inst_eol
);

	// stage 1 copies of everything that leaves from stage 2
	logic s1_v;
	logic [pe_ctrl_pkg::fn_len-1:0] s1_fn;
	logic s1_weight_wrt;
	logic [pe_ctrl_pkg::weight_addr_len-1:0] s1_weight_wrt_addr;
	logic s1_interim_wrt;
	logic [pe_ctrl_pkg::interim_addr_len-1:0] s1_interim_wrt_addr;
	logic s1_pe_neigh_wrt;
	logic s1_pu_neigh_wrt;
	logic [pe_ctrl_pkg::bus_index_len-1:0] s1_pe_bus_wrt_addr;
	logic [pe_ctrl_pkg::bus_index_len-1:0] s1_gb_bus_wrt_addr;
	logic s1_pe_neigh_rq;
	logic s1_pu_neigh_rq;
	logic s1_pe_bus_rq;
	logic s1_gb_bus_rq;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] s1_bus_rd_addr;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] s2_bus_rd_addr;
	logic s1_src0_rq;
	logic s1_src1_rq;
	logic [pe_ctrl_pkg::index_len-1:0] s1_src0_index;
	logic [pe_ctrl_pkg::index_len-1:0] s1_src1_index;
	logic s1_eol;

	// --------------------
	// stage 1
	// --------------------
	// read addresses leave here, the memories add their own cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			{s1_v, s1_fn, s1_eol, s1_weight_wrt, s1_weight_wrt_addr} <= '0;
			{s1_interim_wrt, s1_interim_wrt_addr, s1_pe_neigh_wrt, s1_pu_neigh_wrt} <= '0;
			{s1_pe_bus_wrt_addr, s1_gb_bus_wrt_addr, s1_bus_rd_addr} <= '0;
			{s1_pe_neigh_rq, s1_pu_neigh_rq, s1_pe_bus_rq, s1_gb_bus_rq} <= '0;
			{s1_src0_rq, s1_src1_rq, s1_src0_index, s1_src1_index} <= '0;
			{data_rd_addr, weight_rd_addr, interim_rd_addr0, interim_rd_addr1} <= '0;
			{meta_rd_addr, src0_name, src1_name} <= '0;
		end
		else if (eoc)
		begin
			{s1_v, s1_fn, s1_eol, s1_weight_wrt, s1_weight_wrt_addr} <= '0;
			{s1_interim_wrt, s1_interim_wrt_addr, s1_pe_neigh_wrt, s1_pu_neigh_wrt} <= '0;
			{s1_pe_bus_wrt_addr, s1_gb_bus_wrt_addr, s1_bus_rd_addr} <= '0;
			{s1_pe_neigh_rq, s1_pu_neigh_rq, s1_pe_bus_rq, s1_gb_bus_rq} <= '0;
			{s1_src0_rq, s1_src1_rq, s1_src0_index, s1_src1_index} <= '0;
			{data_rd_addr, weight_rd_addr, interim_rd_addr0, interim_rd_addr1} <= '0;
			{meta_rd_addr, src0_name, src1_name} <= '0;
		end
		else if (advance)
		begin
			s1_v <= inst_v;
			s1_fn <= fn_d;
			s1_eol <= eol_d;
			s1_weight_wrt <= weight_wrt_d;
			s1_weight_wrt_addr <= weight_wrt_addr_d;
			s1_interim_wrt <= interim_wrt_d;
			s1_interim_wrt_addr <= interim_wrt_addr_d;
			s1_pe_neigh_wrt <= pe_neigh_wrt_d;
			s1_pu_neigh_wrt <= pu_neigh_wrt_d;
			s1_pe_bus_wrt_addr <= pe_bus_wrt_addr_d;
			s1_gb_bus_wrt_addr <= gb_bus_wrt_addr_d;
			s1_bus_rd_addr <= bus_rd_addr_d;
			s1_pe_neigh_rq <= pe_neigh_data_rq_d;
			s1_pu_neigh_rq <= pu_neigh_data_rq_d;
			s1_pe_bus_rq <= pe_bus_data_rq_d;
			s1_gb_bus_rq <= gb_bus_data_rq_d;
			s1_src0_rq <= src0_rq_d;
			s1_src1_rq <= src1_rq_d;
			s1_src0_index <= src0_index_d;
			s1_src1_index <= src1_index_d;
			data_rd_addr <= data_rd_addr_d;
			weight_rd_addr <= weight_rd_addr_d;
			interim_rd_addr0 <= interim_rd_addr0_d;
			interim_rd_addr1 <= interim_rd_addr1_d;
			meta_rd_addr <= meta_rd_addr_d;
			src0_name <= src0_name_d;
			src1_name <= src1_name_d;
		end
	end

	// --------------------
	// stage 2
	// --------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			{inst_out_v, pe_compute_fn, inst_eol, weight_wrt, weight_wrt_addr} <= '0;
			{interim_wrt, interim_wrt_addr, pe_neigh_wrt, pu_neigh_wrt} <= '0;
			{pe_bus_wrt_addr, gb_bus_wrt_addr, s2_bus_rd_addr} <= '0;
			{pe_neigh_data_rq, pu_neigh_data_rq, pe_bus_data_rq, gb_bus_data_rq} <= '0;
			{src0_rq, src1_rq, src0_index, src1_index} <= '0;
		end
		else if (eoc)
		begin
			{inst_out_v, pe_compute_fn, inst_eol, weight_wrt, weight_wrt_addr} <= '0;
			{interim_wrt, interim_wrt_addr, pe_neigh_wrt, pu_neigh_wrt} <= '0;
			{pe_bus_wrt_addr, gb_bus_wrt_addr, s2_bus_rd_addr} <= '0;
			{pe_neigh_data_rq, pu_neigh_data_rq, pe_bus_data_rq, gb_bus_data_rq} <= '0;
			{src0_rq, src1_rq, src0_index, src1_index} <= '0;
		end
		else if (advance)
		begin
			inst_out_v <= s1_v;
			pe_compute_fn <= s1_fn;
			inst_eol <= s1_eol;
			weight_wrt <= s1_weight_wrt;
			weight_wrt_addr <= s1_weight_wrt_addr;
			interim_wrt <= s1_interim_wrt;
			interim_wrt_addr <= s1_interim_wrt_addr;
			pe_neigh_wrt <= s1_pe_neigh_wrt;
			pu_neigh_wrt <= s1_pu_neigh_wrt;
			pe_bus_wrt_addr <= s1_pe_bus_wrt_addr;
			gb_bus_wrt_addr <= s1_gb_bus_wrt_addr;
			s2_bus_rd_addr <= s1_bus_rd_addr;
			pe_neigh_data_rq <= s1_pe_neigh_rq;
			pu_neigh_data_rq <= s1_pu_neigh_rq;
			pe_bus_data_rq <= s1_pe_bus_rq;
			gb_bus_data_rq <= s1_gb_bus_rq;
			src0_rq <= s1_src0_rq;
			src1_rq <= s1_src1_rq;
			src0_index <= s1_src0_index;
			src1_index <= s1_src1_index;
		end
	end

	// both buses read the same slot, the request picks which bus answers
	assign pe_bus_rd_addr = s2_bus_rd_addr;
	assign gb_bus_rd_addr = s2_bus_rd_addr;

	// back-pressure freezes the outputs seen by the core
	a_stage2_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(!advance && !eoc) |=> $stable({inst_out_v, pe_compute_fn, inst_eol,
			weight_wrt, weight_wrt_addr, interim_wrt, interim_wrt_addr,
			pe_neigh_wrt, pu_neigh_wrt, pe_bus_wrt_addr, gb_bus_wrt_addr,
			pe_neigh_data_rq, pu_neigh_data_rq, pe_bus_data_rq, gb_bus_data_rq,
			s2_bus_rd_addr, src0_rq, src1_rq, src0_index, src1_index}))
		else $error("pe_ctrl_pipe: stage 2 moved while stalled");

endmodule

`default_nettype wire

//--- source/pe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl_top (
	input  wire clk,
	input  wire arst_n,
	input  wire eoc,
	input  wire [pe_ctrl_pkg::inst_len-1:0] inst_in,
	input  wire inst_in_v,
	input  wire inst_stall,
	input  wire bus_contention,
	output logic [pe_ctrl_pkg::fn_len-1:0] pe_compute_fn,
	output logic inst_out_v,
	output logic weight_wrt,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_wrt_addr,
	output logic interim_wrt,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_wrt_addr,
	output logic pe_neigh_wrt,
	output logic pu_neigh_wrt,
	output logic [pe_ctrl_pkg::bus_index_len-1:0] pe_bus_wrt_addr,
	output logic [pe_ctrl_pkg::bus_index_len-1:0] gb_bus_wrt_addr,
	output logic [pe_ctrl_pkg::data_addr_len-1:0] data_rd_addr,
	output logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_rd_addr,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr0,
	output logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr1,
	output logic [pe_ctrl_pkg::meta_addr_len-1:0] meta_rd_addr,
	output logic pe_neigh_data_rq,
	output logic pu_neigh_data_rq,
	output logic pe_bus_data_rq,
	output logic gb_bus_data_rq,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] pe_bus_rd_addr,
	output logic [pe_ctrl_pkg::bus_addr_len-1:0] gb_bus_rd_addr,
	output logic src0_rq,
	output logic src1_rq,
	output logic [pe_ctrl_pkg::index_len-1:0] src0_index,
	output logic [pe_ctrl_pkg::index_len-1:0] src1_index,
	output logic [pe_ctrl_pkg::name_len-1:0] src0_name,
	output logic [pe_ctrl_pkg::name_len-1:0] src1_name,
	output logic inst_eol
);

	logic advance;

	// decoded word, ahead of the pipeline
	logic [pe_ctrl_pkg::fn_len-1:0] fn_d;
	logic [pe_ctrl_pkg::name_len-1:0] src0_name_d;
	logic [pe_ctrl_pkg::name_len-1:0] src1_name_d;
	logic [pe_ctrl_pkg::index_len-1:0] src0_index_d;
	logic [pe_ctrl_pkg::index_len-1:0] src1_index_d;
	logic weight_wrt_d;
	logic interim_wrt_d;
	logic pe_neigh_wrt_d;
	logic pu_neigh_wrt_d;
	logic pe_bus_wrt;
	logic gb_bus_wrt;
	logic eol_d;
	logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_wrt_addr_d;
	logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_wrt_addr_d;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] pe_bus_dest_addr;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] gb_bus_dest_addr;
	logic [pe_ctrl_pkg::bus_index_len-1:0] pe_bus_wrt_addr_d;
	logic [pe_ctrl_pkg::bus_index_len-1:0] gb_bus_wrt_addr_d;

	// per source decode results, index 0 and 1
	logic [pe_ctrl_pkg::data_addr_len-1:0] src_data_rd [2];
	logic [pe_ctrl_pkg::weight_addr_len-1:0] src_weight_rd [2];
	logic [pe_ctrl_pkg::interim_addr_len-1:0] src_interim_rd [2];
	logic [pe_ctrl_pkg::meta_addr_len-1:0] src_meta_rd [2];
	logic [pe_ctrl_pkg::bus_addr_len-1:0] src_bus_rd [2];
	logic [1:0] src_pe_neigh_rq;
	logic [1:0] src_pu_neigh_rq;
	logic [1:0] src_pe_bus_rq;
	logic [1:0] src_gb_bus_rq;

	// merged, into the pipeline
	logic [pe_ctrl_pkg::data_addr_len-1:0] data_rd_addr_d;
	logic [pe_ctrl_pkg::weight_addr_len-1:0] weight_rd_addr_d;
	logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr0_d;
	logic [pe_ctrl_pkg::interim_addr_len-1:0] interim_rd_addr1_d;
	logic [pe_ctrl_pkg::meta_addr_len-1:0] meta_rd_addr_d;
	logic [pe_ctrl_pkg::bus_addr_len-1:0] bus_rd_addr_d;
	logic pe_neigh_data_rq_d;
	logic pu_neigh_data_rq_d;
	logic pe_bus_data_rq_d;
	logic gb_bus_data_rq_d;
	logic src0_rq_d;
	logic src1_rq_d;

	assign advance = !(inst_stall || bus_contention);

	inst_field_split split_i (
		.inst_in(inst_in),
		.inst_in_v(inst_in_v),
		.fn(fn_d),
		.src0_name(src0_name_d),
		.src0_index(src0_index_d),
		.src1_name(src1_name_d),
		.src1_index(src1_index_d),
		.weight_wrt(weight_wrt_d),
		.weight_wrt_addr(weight_wrt_addr_d),
		.interim_wrt(interim_wrt_d),
		.interim_wrt_addr(interim_wrt_addr_d),
		.pe_neigh_wrt(pe_neigh_wrt_d),
		.pu_neigh_wrt(pu_neigh_wrt_d),
		.pe_bus_wrt(pe_bus_wrt),
		.gb_bus_wrt(gb_bus_wrt),
		.pe_bus_wrt_addr(pe_bus_dest_addr),
		.gb_bus_wrt_addr(gb_bus_dest_addr),
		.eol(eol_d)
	);

	// bus write strobe rides in bit 0
	assign pe_bus_wrt_addr_d = {pe_bus_dest_addr, pe_bus_wrt};
	assign gb_bus_wrt_addr_d = {gb_bus_dest_addr, gb_bus_wrt};

	// --------------------
	// source decode
	// --------------------
	src_operand_decode src0_dec_i (
		.name(src0_name_d),
		.index(src0_index_d),
		.valid(inst_in_v),
		.data_rd_addr(src_data_rd[0]),
		.weight_rd_addr(src_weight_rd[0]),
		.interim_rd_addr(src_interim_rd[0]),
		.meta_rd_addr(src_meta_rd[0]),
		.pe_neigh_rq(src_pe_neigh_rq[0]),
		.pu_neigh_rq(src_pu_neigh_rq[0]),
		.pe_bus_rq(src_pe_bus_rq[0]),
		.gb_bus_rq(src_gb_bus_rq[0]),
		.bus_rd_addr(src_bus_rd[0]),
		.rq(src0_rq_d)
	);

	src_operand_decode src1_dec_i (
		.name(src1_name_d),
		.index(src1_index_d),
		.valid(inst_in_v),
		.data_rd_addr(src_data_rd[1]),
		.weight_rd_addr(src_weight_rd[1]),
		.interim_rd_addr(src_interim_rd[1]),
		.meta_rd_addr(src_meta_rd[1]),
		.pe_neigh_rq(src_pe_neigh_rq[1]),
		.pu_neigh_rq(src_pu_neigh_rq[1]),
		.pe_bus_rq(src_pe_bus_rq[1]),
		.gb_bus_rq(src_gb_bus_rq[1]),
		.bus_rd_addr(src_bus_rd[1]),
		.rq(src1_rq_d)
	);

	// a non-matching source drives zeros, so OR merges cleanly
	assign data_rd_addr_d = src_data_rd[0] | src_data_rd[1];
	assign weight_rd_addr_d = src_weight_rd[0] | src_weight_rd[1];
	assign meta_rd_addr_d = src_meta_rd[0] | src_meta_rd[1];
	assign bus_rd_addr_d = src_bus_rd[0] | src_bus_rd[1];
	// interim has one read port per source
	assign interim_rd_addr0_d = src_interim_rd[0];
	assign interim_rd_addr1_d = src_interim_rd[1];
	assign pe_neigh_data_rq_d = |src_pe_neigh_rq;
	assign pu_neigh_data_rq_d = |src_pu_neigh_rq;
	assign pe_bus_data_rq_d = |src_pe_bus_rq;
	assign gb_bus_data_rq_d = |src_gb_bus_rq;

	pe_ctrl_pipe pipe_i (
		.inst_v(inst_in_v),
		.*
	);

	// an end-of-list word never carries a write down the pipe
	a_eol_no_wrt: assert property (@(posedge clk) disable iff (!arst_n)
		inst_eol |-> !(weight_wrt || interim_wrt || pe_neigh_wrt || pu_neigh_wrt
			|| pe_bus_wrt_addr[0] || gb_bus_wrt_addr[0]))
		else $error("pe_ctrl_top: inst_eol with a write strobe");

endmodule

`default_nettype wire

//--- include/pe_ctrl_tb_model.svh
`ifndef PE_CTRL_TB_MODEL_SVH
`define PE_CTRL_TB_MODEL_SVH

// dest holds the 19 destination bits below source 1
function automatic logic [43:0] make_inst(input logic [2:0] fn, input logic [2:0] n0,
	input logic [7:0] i0, input logic [2:0] n1, input logic [7:0] i1, input logic [18:0] dest);
	logic [43:0] w;
	w = '0;
	w[pe_ctrl_pkg::fn_lsb +: 3] = fn;
	w[pe_ctrl_pkg::src0_name_lsb +: 3] = n0;
	w[pe_ctrl_pkg::src0_index_lsb +: 8] = i0;
	w[pe_ctrl_pkg::src1_name_lsb +: 3] = n1;
	w[pe_ctrl_pkg::src1_index_lsb +: 8] = i1;
	w[18:0] = dest;
	return w;
endfunction

// stage 1 view: data, weight, interim0, interim1, meta, src0_name, src1_name
function automatic logic [21:0] model_stage1(input logic [43:0] w);
	logic [2:0] n0;
	logic [2:0] n1;
	logic [7:0] i0;
	logic [7:0] i1;
	logic [4:0] d;
	logic [4:0] wt;
	logic [1:0] r0;
	logic [1:0] r1;
	logic [1:0] m;
	n0 = w[pe_ctrl_pkg::src0_name_lsb +: 3];
	n1 = w[pe_ctrl_pkg::src1_name_lsb +: 3];
	i0 = w[pe_ctrl_pkg::src0_index_lsb +: 8];
	i1 = w[pe_ctrl_pkg::src1_index_lsb +: 8];
	d = (n0 == pe_ctrl_pkg::ns_data ? i0[4:0] : 5'd0)
		| (n1 == pe_ctrl_pkg::ns_data ? i1[4:0] : 5'd0);
	wt = (n0 == pe_ctrl_pkg::ns_weight ? i0[4:0] : 5'd0)
		| (n1 == pe_ctrl_pkg::ns_weight ? i1[4:0] : 5'd0);
	m = (n0 == pe_ctrl_pkg::ns_meta ? i0[1:0] : 2'd0)
		| (n1 == pe_ctrl_pkg::ns_meta ? i1[1:0] : 2'd0);
	r0 = n0 == pe_ctrl_pkg::ns_interim ? i0[1:0] : 2'd0;
	r1 = n1 == pe_ctrl_pkg::ns_interim ? i1[1:0] : 2'd0;
	return {d, wt, r0, r1, m, n0, n1};
endfunction

// stage 2 view, 52 bits, order matches the stage 2 checks in the testbench
function automatic logic [51:0] model_stage2(input logic [43:0] w, input logic v);
	logic [2:0] n0;
	logic [2:0] n1;
	logic [7:0] i0;
	logic [7:0] i1;
	logic [2:0] pb;
	logic [2:0] gb;
	logic [3:0] rq;
	logic [2:0] brd;
	logic ww;
	logic iw;
	logic pen;
	logic pun;
	logic eol;
	n0 = w[pe_ctrl_pkg::src0_name_lsb +: 3];
	n1 = w[pe_ctrl_pkg::src1_name_lsb +: 3];
	i0 = w[pe_ctrl_pkg::src0_index_lsb +: 8];
	i1 = w[pe_ctrl_pkg::src1_index_lsb +: 8];
	pb = w[7:5];
	gb = w[3:1];
	ww = v && w[15];
	iw = v && w[18];
	pen = v && w[9];
	pun = v && w[8];
	// pe neigh, pu neigh, pe bus, gb bus
	rq = '0;
	rq[3] = v && ((n0 == pe_ctrl_pkg::ns_neighbor && !i0[0])
		|| (n1 == pe_ctrl_pkg::ns_neighbor && !i1[0]));
	rq[2] = v && ((n0 == pe_ctrl_pkg::ns_neighbor && i0[0])
		|| (n1 == pe_ctrl_pkg::ns_neighbor && i1[0]));
	rq[1] = v && ((n0 == pe_ctrl_pkg::ns_bus && !i0[0])
		|| (n1 == pe_ctrl_pkg::ns_bus && !i1[0]));
	rq[0] = v && ((n0 == pe_ctrl_pkg::ns_bus && i0[0])
		|| (n1 == pe_ctrl_pkg::ns_bus && i1[0]));
	brd = (n0 == pe_ctrl_pkg::ns_bus ? i0[3:1] : 3'd0)
		| (n1 == pe_ctrl_pkg::ns_bus ? i1[3:1] : 3'd0);
	eol = v && n0 == pe_ctrl_pkg::ns_none && n1 == pe_ctrl_pkg::ns_none
		&& !(w[18] || w[15] || w[9] || w[8]) && pb == 3'd0 && gb == 3'd0;
	return {w[pe_ctrl_pkg::fn_lsb +: 3], v,
		ww, ww ? w[14:10] : 5'd0, iw, iw ? w[17:16] : 2'd0, pen, pun,
		(v && pb != 3'd0) ? {pb, 1'b1} : 4'd0, (v && gb != 3'd0) ? {gb, 1'b1} : 4'd0,
		rq, brd, brd, v && n0 != pe_ctrl_pkg::ns_none, v && n1 != pe_ctrl_pkg::ns_none,
		i0, i1, eol};
endfunction

`endif

//--- tests/pe_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl_tb;

	`include "pe_ctrl_tb_model.svh"

	logic clk;
	logic arst_n;
	logic eoc;
	logic [43:0] inst_in;
	logic inst_in_v;
	logic inst_stall;
	logic bus_contention;
	wire [2:0] pe_compute_fn;
	wire inst_out_v;
	wire weight_wrt;
	wire interim_wrt;
	wire pe_neigh_wrt;
	wire pu_neigh_wrt;
	wire [4:0] weight_wrt_addr;
	wire [4:0] data_rd_addr;
	wire [4:0] weight_rd_addr;
	wire [1:0] interim_wrt_addr;
	wire [1:0] interim_rd_addr0;
	wire [1:0] interim_rd_addr1;
	wire [1:0] meta_rd_addr;
	wire [3:0] pe_bus_wrt_addr;
	wire [3:0] gb_bus_wrt_addr;
	wire pe_neigh_data_rq;
	wire pu_neigh_data_rq;
	wire pe_bus_data_rq;
	wire gb_bus_data_rq;
	wire [2:0] pe_bus_rd_addr;
	wire [2:0] gb_bus_rd_addr;
	wire [2:0] src0_name;
	wire [2:0] src1_name;
	wire src0_rq;
	wire src1_rq;
	wire inst_eol;
	wire [7:0] src0_index;
	wire [7:0] src1_index;

	logic [21:0] exp_s1;
	logic [51:0] mid_s2;
	logic [51:0] exp_s2;
	integer seed;
	integer errors;
	integer err_start;
	integer passes;
	integer fails;
	integer cycles;
	integer in_count;
	integer out_count;
	logic count_en;
	wire advance = !(inst_stall || bus_contention);

	pe_ctrl_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = !clk;
	end

	// --------------------
	// expected-value pipeline
	// --------------------
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exp_s1 <= '0;
			mid_s2 <= '0;
			exp_s2 <= '0;
		end
		else if (eoc)
		begin
			exp_s1 <= '0;
			mid_s2 <= '0;
			exp_s2 <= '0;
		end
		else if (advance)
		begin
			exp_s1 <= model_stage1(inst_in);
			mid_s2 <= model_stage2(inst_in, inst_in_v);
			exp_s2 <= mid_s2;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (count_en && advance && !eoc && inst_in_v)
			in_count <= in_count + 1;
		if (count_en && advance && !eoc && inst_out_v)
			out_count <= out_count + 1;
		if (cycles >= 1000)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	task automatic report_err(input string what);
		errors = errors + 1;
		$display("ERR %0t: wrong value on %s", $time, what);
	endtask

	// --------------------
	// output checks
	// --------------------
	a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n)
		{data_rd_addr, weight_rd_addr, interim_rd_addr0, interim_rd_addr1, meta_rd_addr}
		== exp_s1[21:6]) else report_err("memory read addresses");
	a_names: assert property (@(posedge clk) disable iff (!arst_n)
		{src0_name, src1_name} == exp_s1[5:0]) else report_err("src0_name/src1_name");
	a_fn_v: assert property (@(posedge clk) disable iff (!arst_n)
		{pe_compute_fn, inst_out_v} == exp_s2[51:48]) else report_err("pe_compute_fn/inst_out_v");
	a_wrt: assert property (@(posedge clk) disable iff (!arst_n)
		{weight_wrt, weight_wrt_addr, interim_wrt, interim_wrt_addr, pe_neigh_wrt, pu_neigh_wrt,
		pe_bus_wrt_addr, gb_bus_wrt_addr} == exp_s2[47:29]) else report_err("write strobes");
	a_rq: assert property (@(posedge clk) disable iff (!arst_n)
		{pe_neigh_data_rq, pu_neigh_data_rq, pe_bus_data_rq, gb_bus_data_rq, pe_bus_rd_addr,
		gb_bus_rd_addr, src0_rq, src1_rq} == exp_s2[28:17]) else report_err("data path requests");
	a_idx: assert property (@(posedge clk) disable iff (!arst_n)
		{src0_index, src1_index} == exp_s2[16:1]) else report_err("src0_index/src1_index");
	a_eol: assert property (@(posedge clk) disable iff (!arst_n)
		inst_eol == exp_s2[0]) else report_err("inst_eol");

	task automatic send(input logic [43:0] w, input logic v);
		@(negedge clk);
		inst_in = w;
		inst_in_v = v;
	endtask

	task automatic flush();
		repeat (3) send('0, 1'b0);
	endtask

	task automatic end_test(input string name);
		@(negedge clk);
		if (errors == err_start)
		begin
			passes = passes + 1;
			$display("test %s: ok", name);
		end
		else
		begin
			fails = fails + 1;
			$display("test %s: %0d errors", name, errors - err_start);
		end
		err_start = errors;
	endtask

	initial
	begin
		logic [2:0] ns;
		logic [43:0] w;
		seed = 32'h478436bd;
		{errors, err_start, passes, fails, cycles, in_count, out_count} = '0;
		count_en = 1'b0;
		{eoc, inst_in, inst_in_v, inst_stall, bus_contention} = '0;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		flush();
		end_test("reset_idle");

		// memory namespaces, both sources the same kind
		for (int k = 1; k <= 4; k++)
		begin
			ns = 3'(k);
			send(make_inst(3'(k), ns, 8'($random(seed)), ns, 8'($random(seed)), '0), 1'b1);
		end
		flush();
		end_test("memory_reads");

		// every side combination for neighbor and bus
		for (int k = 0; k < 16; k++)
		begin
			w = make_inst(3'd5, k[3] ? pe_ctrl_pkg::ns_bus : pe_ctrl_pkg::ns_neighbor,
				{7'($random(seed)), k[0]},
				k[2] ? pe_ctrl_pkg::ns_bus : pe_ctrl_pkg::ns_neighbor,
				{7'($random(seed)), k[1]}, '0);
			send(w, 1'b1);
		end
		flush();
		end_test("neighbor_bus");

		repeat (12)
			send(make_inst(3'($random(seed)), '0, '0, '0, '0, 19'($random(seed))), 1'b1);
		flush();
		end_test("destinations");

		send('0, 1'b1);
		send('0, 1'b0);
		send(make_inst(3'd2, '0, 8'h33, '0, 8'h44, '0), 1'b1);
		flush();
		end_test("end_of_list");

		repeat (3)
			send(make_inst(3'd1, pe_ctrl_pkg::ns_data, 8'h15, pe_ctrl_pkg::ns_bus, 8'h0b,
				19'h7ffff), 1'b1);
		eoc = 1'b1;
		send(make_inst(3'd3, pe_ctrl_pkg::ns_meta, 8'h02, '0, '0, 19'h00100), 1'b1);
		eoc = 1'b0;
		send('0, 1'b0);
		send('0, 1'b0);
		send(make_inst(3'd4, pe_ctrl_pkg::ns_weight, 8'h1f, '0, '0, 19'h08000), 1'b1);
		flush();
		end_test("eoc_clear");

		// word is held until a rising edge with advance takes it
		count_en = 1'b1;
		w = 44'({$random(seed), $random(seed)});
		for (int k = 0; k < 60; )
		begin
			@(negedge clk);
			if (advance)
			begin
				w = 44'({$random(seed), $random(seed)});
				k++;
			end
			inst_in = w;
			inst_in_v = ($random(seed) % 4) != 0;
			inst_stall = ($random(seed) % 3) == 0;
			bus_contention = ($random(seed) % 4) == 0;
		end
		@(negedge clk);
		{inst_stall, bus_contention} = '0;
		flush();
		count_en = 1'b0;
		a_count: assert (in_count == out_count)
		else
		begin
			errors = errors + 1;
			$display("ERR %0t: %0d taken but %0d left the pipeline", $time, in_count, out_count);
		end
		end_test("random_stall");

		$display("tests passed %0d, failed %0d", passes, fails);
		if (fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/pe_ctrl_pkg.sv
source/inst_field_split.sv
source/src_operand_decode.sv
source/pe_ctrl_pipe.sv
source/pe_ctrl_top.sv
tests/pe_ctrl_tb.sv

//--- Makefile
SIM := obj_dir/Vpe_ctrl_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

$(SIM): vlog.f source/*.sv tests/*.sv include/*.svh
	verilator --binary --assert --timing --top-module pe_ctrl_tb -f vlog.f

test: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
